// ==== rtl/cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

    // ****************************************
    // Datapath widths
    // ****************************************
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;     // I-type immediate field

    // ****************************************
    // Vector types
    // ****************************************
    typedef logic [WORD_W-1:0]     word_t;      // Data or operand word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [WORD_W-1:0]     inst_t;

endpackage

// ==== rtl/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // ****************************************
    // Instruction fields
    // ****************************************
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_PREF    = 6'b110011
    } op_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,
        FN_SYNC = 6'b001111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // ****************************************
    // Execute stage controls
    // ****************************************
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_SLLV  = 8'b00000100,
        ALU_SRLV  = 8'b00000110,
        ALU_SRAV  = 8'b00000111,
        ALU_MOVZ  = 8'b00001010,
        ALU_MOVN  = 8'b00001011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SLTI  = 8'b01010111,
        ALU_SLTIU = 8'b01011000,
        ALU_ANDI  = 8'b01011001,
        ALU_ORI   = 8'b01011010,    // LUI shares this one
        ALU_XORI  = 8'b01011011,
        ALU_SLL   = 8'b01111100
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alusel_e;

    // When the result may be written back
    typedef enum logic [1:0] {
        MOV_NEVER  = 2'b00,
        MOV_ALWAYS = 2'b01,
        MOV_NZ     = 2'b10,     // Only if operand 2 != 0
        MOV_Z      = 2'b11
    } mov_cond_e;

endpackage

// ==== rtl/id_dec_if.sv ====
`timescale 1ns/1ps

interface id_dec_if;
    import cpu_cfg_pkg::*;

    logic      reg1_re;
    reg_addr_t reg1_addr;
    logic      reg2_re;
    reg_addr_t reg2_addr;
    word_t     imm;         // Immediate or shift amount

    modport dec (
        output reg1_re, reg1_addr, reg2_re, reg2_addr, imm
    );

    modport sel (
        input reg1_re, reg1_addr, reg2_re, reg2_addr, imm
    );

endinterface

// ==== rtl/id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
    input  cpu_cfg_pkg::inst_t      inst_i,
    id_dec_if.dec                   dec,
    output mips_isa_pkg::aluop_e    aluop_o,
    output mips_isa_pkg::alusel_e   alusel_o,
    output cpu_cfg_pkg::reg_addr_t  wd_o,
    output mips_isa_pkg::mov_cond_e mov_cond_o,
    output logic                    instvalid_o
);
    import cpu_cfg_pkg::*;
    import mips_isa_pkg::*;

    logic [5:0]       op;
    logic [5:0]       funct;
    reg_addr_t        rs;
    reg_addr_t        rt;
    reg_addr_t        rd;
    logic [4:0]       sa;
    logic [IMM_W-1:0] imm16;
    logic             fixed_shift;

    function automatic aluop_e funct_aluop(input logic [5:0] fn);
        case (fn)
            FN_SLL:  return ALU_SLL;
            FN_SRL:  return ALU_SRL;
            FN_SRA:  return ALU_SRA;
            FN_SLLV: return ALU_SLLV;
            FN_SRLV: return ALU_SRLV;
            FN_SRAV: return ALU_SRAV;
            FN_MOVZ: return ALU_MOVZ;
            FN_MOVN: return ALU_MOVN;
            FN_ADD:  return ALU_ADD;
            FN_ADDU: return ALU_ADDU;
            FN_SUB:  return ALU_SUB;
            FN_SUBU: return ALU_SUBU;
            FN_AND:  return ALU_AND;
            FN_OR:   return ALU_OR;
            FN_XOR:  return ALU_XOR;
            FN_NOR:  return ALU_NOR;
            FN_SLT:  return ALU_SLT;
            FN_SLTU: return ALU_SLTU;
            default: return ALU_NOP;    // SYNC and unknown
        endcase
    endfunction

    // ****************************************
    // Field split
    // ****************************************
    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[IMM_W-1:0];

    assign dec.reg1_addr = rs;
    assign dec.reg2_addr = rt;

    // SLL/SRL/SRA need rs == 0
    assign fixed_shift = (rs == '0) &&
                         (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA);

    // ****************************************
    // Decode
    // ****************************************
    always_comb begin
        aluop_o     = ALU_NOP;
        alusel_o    = SEL_NOP;
        wd_o        = rd;
        mov_cond_o  = MOV_NEVER;
        instvalid_o = 1'b0;
        dec.reg1_re = 1'b0;
        dec.reg2_re = 1'b0;
        dec.imm     = '0;

        case (op)
            OP_SPECIAL: begin
                if (fixed_shift) begin
                    dec.reg2_re = 1'b1;     // Operand 1 carries sa
                    dec.imm     = {{(WORD_W - $bits(sa)){1'b0}}, sa};
                    aluop_o     = funct_aluop(funct);
                    alusel_o    = SEL_SHIFT;
                    mov_cond_o  = MOV_ALWAYS;
                    instvalid_o = 1'b1;
                end else if (sa == '0) begin
                    dec.reg1_re = 1'b1;
                    dec.reg2_re = 1'b1;
                    aluop_o     = funct_aluop(funct);
                    mov_cond_o  = MOV_ALWAYS;
                    instvalid_o = 1'b1;
                    case (funct)
                        FN_AND, FN_OR, FN_XOR, FN_NOR: alusel_o = SEL_LOGIC;
                        FN_SLLV, FN_SRLV, FN_SRAV:     alusel_o = SEL_SHIFT;
                        FN_SLT, FN_SLTU, FN_ADD, FN_ADDU,
                        FN_SUB, FN_SUBU:               alusel_o = SEL_ARITH;
                        FN_MOVN: begin
                            alusel_o   = SEL_MOVE;
                            mov_cond_o = MOV_NZ;
                        end
                        FN_MOVZ: begin
                            alusel_o   = SEL_MOVE;
                            mov_cond_o = MOV_Z;
                        end
                        FN_SYNC: mov_cond_o = MOV_NEVER;
                        default: begin
                            aluop_o     = ALU_NOP;
                            dec.reg1_re = 1'b0;
                            dec.reg2_re = 1'b0;
                            mov_cond_o  = MOV_NEVER;
                            instvalid_o = 1'b0;
                        end
                    endcase
                end
            end

            OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
                dec.reg1_re = 1'b1;
                wd_o        = rt;       // I-type writes rt
                mov_cond_o  = MOV_ALWAYS;
                instvalid_o = 1'b1;
                case (op)
                    OP_ORI, OP_LUI: aluop_o = ALU_ORI;
                    OP_ANDI:        aluop_o = ALU_ANDI;
                    OP_XORI:        aluop_o = ALU_XORI;
                    OP_SLTI:        aluop_o = ALU_SLTI;
                    OP_SLTIU:       aluop_o = ALU_SLTIU;
                    OP_ADDI:        aluop_o = ALU_ADDI;
                    default:        aluop_o = ALU_ADDIU;
                endcase
                case (op)
                    OP_LUI: begin
                        alusel_o = SEL_LOGIC;
                        dec.imm  = {imm16, {(WORD_W - IMM_W){1'b0}}};
                    end
                    OP_ORI, OP_ANDI, OP_XORI: begin
                        alusel_o = SEL_LOGIC;
                        dec.imm  = {{(WORD_W - IMM_W){1'b0}}, imm16};
                    end
                    default: begin
                        alusel_o = SEL_ARITH;
                        dec.imm  = {{(WORD_W - IMM_W){imm16[IMM_W-1]}}, imm16};
                    end
                endcase
            end

            OP_PREF: instvalid_o = 1'b1;    // Valid no-op

            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/id_regfile.sv ====
`timescale 1ns/1ps

module id_regfile (
    input  logic                   clk,
    input  logic                   arst_n_i,
    id_dec_if.sel                  rd,
    input  logic                   wb_we_i,
    input  cpu_cfg_pkg::reg_addr_t wb_addr_i,
    input  cpu_cfg_pkg::word_t     wb_wdata_i,
    output cpu_cfg_pkg::word_t     rdata1_o,
    output cpu_cfg_pkg::word_t     rdata2_o
);
    import cpu_cfg_pkg::*;

    word_t regs [NUM_REGS];

    // Register 0 is never written and stays zero
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_wdata_i;
        end
    end

    function automatic word_t read_port(input logic re, input reg_addr_t addr);
        word_t data;
        if (!re || addr == '0) begin
            data = '0;
        end else if (wb_we_i && wb_addr_i == addr) begin
            data = wb_wdata_i;      // Write-through
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rdata1_o = read_port(rd.reg1_re, rd.reg1_addr);
        rdata2_o = read_port(rd.reg2_re, rd.reg2_addr);
    end

endmodule

// ==== rtl/id_operand_sel.sv ====
`timescale 1ns/1ps

module id_operand_sel (
    id_dec_if.sel                  sel,
    input  cpu_cfg_pkg::word_t     rdata1_i,
    input  cpu_cfg_pkg::word_t     rdata2_i,
    input  logic                   ex_wreg_i,
    input  cpu_cfg_pkg::reg_addr_t ex_wd_i,
    input  cpu_cfg_pkg::word_t     ex_wdata_i,
    input  logic                   mem_wreg_i,
    input  cpu_cfg_pkg::reg_addr_t mem_wd_i,
    input  cpu_cfg_pkg::word_t     mem_wdata_i,
    output cpu_cfg_pkg::word_t     reg1_o,
    output cpu_cfg_pkg::word_t     reg2_o
);
    import cpu_cfg_pkg::*;

    // Execute beats memory beats register file
    function automatic word_t pick_operand(
        input logic      re,
        input reg_addr_t addr,
        input word_t     rf_data,
        input word_t     imm
    );
        word_t data;
        if (!re) begin
            data = imm;
        end else if (ex_wreg_i && ex_wd_i == addr) begin
            data = ex_wdata_i;
        end else if (mem_wreg_i && mem_wd_i == addr) begin
            data = mem_wdata_i;
        end else begin
            data = rf_data;
        end
        return data;
    endfunction

    always_comb begin
        reg1_o = pick_operand(sel.reg1_re, sel.reg1_addr, rdata1_i, sel.imm);
        reg2_o = pick_operand(sel.reg2_re, sel.reg2_addr, rdata2_i, sel.imm);
    end

endmodule

// ==== rtl/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  mips_isa_pkg::aluop_e    aluop_i,
    input  mips_isa_pkg::alusel_e   alusel_i,
    input  cpu_cfg_pkg::reg_addr_t  wd_i,
    input  mips_isa_pkg::mov_cond_e mov_cond_i,
    input  logic                    instvalid_i,
    input  cpu_cfg_pkg::word_t      reg1_i,
    input  cpu_cfg_pkg::word_t      reg2_i,
    output mips_isa_pkg::aluop_e    aluop_o,
    output mips_isa_pkg::alusel_e   alusel_o,
    output cpu_cfg_pkg::reg_addr_t  wd_o,
    output logic                    instvalid_o,
    output cpu_cfg_pkg::word_t      reg1_o,
    output cpu_cfg_pkg::word_t      reg2_o,
    output logic                    wreg_o
);
    import cpu_cfg_pkg::*;
    import mips_isa_pkg::*;

    logic wreg_nxt;

    // MOVN/MOVZ test on forwarded operand 2
    always_comb begin
        case (mov_cond_i)
            MOV_ALWAYS: wreg_nxt = 1'b1;
            MOV_NZ:     wreg_nxt = (reg2_i != '0);
            MOV_Z:      wreg_nxt = (reg2_i == '0);
            default:    wreg_nxt = 1'b0;
        endcase
    end

    // ****************************************
    // ID/EX register
    // ****************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aluop_o     <= ALU_NOP;
            alusel_o    <= SEL_NOP;
            wd_o        <= '0;
            instvalid_o <= 1'b0;
            reg1_o      <= '0;
            reg2_o      <= '0;
            wreg_o      <= 1'b0;
        end else begin
            aluop_o     <= aluop_i;
            alusel_o    <= alusel_i;
            wd_o        <= wd_i;
            instvalid_o <= instvalid_i;
            reg1_o      <= reg1_i;
            reg2_o      <= reg2_i;
            wreg_o      <= wreg_nxt;
        end
    end

endmodule

// ==== rtl/id_stage_top.sv ====
`timescale 1ns/1ps

module id_stage_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  cpu_cfg_pkg::inst_t     inst_i,
    // Execute stage forwarding
    input  logic                   ex_wreg_i,
    input  cpu_cfg_pkg::reg_addr_t ex_wd_i,
    input  cpu_cfg_pkg::word_t     ex_wdata_i,
    // Memory stage forwarding
    input  logic                   mem_wreg_i,
    input  cpu_cfg_pkg::reg_addr_t mem_wd_i,
    input  cpu_cfg_pkg::word_t     mem_wdata_i,
    // Write-back
    input  logic                   wb_we_i,
    input  cpu_cfg_pkg::reg_addr_t wb_addr_i,
    input  cpu_cfg_pkg::word_t     wb_wdata_i,
    output mips_isa_pkg::aluop_e   aluop_o,
    output mips_isa_pkg::alusel_e  alusel_o,
    output cpu_cfg_pkg::word_t     reg1_o,
    output cpu_cfg_pkg::word_t     reg2_o,
    output cpu_cfg_pkg::reg_addr_t wd_o,
    output logic                   wreg_o,
    output logic                   instvalid_o
);
    import cpu_cfg_pkg::*;
    import mips_isa_pkg::*;

    aluop_e    dec_aluop;
    alusel_e   dec_alusel;
    reg_addr_t dec_wd;
    mov_cond_e dec_mov_cond;
    logic      dec_instvalid;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     sel_reg1;
    word_t     sel_reg2;

    id_dec_if u_dec_if ();

    // ****************************************
    // Decode and operand fetch
    // ****************************************
    id_decoder u_id_decoder (
        .inst_i      (inst_i),
        .dec         (u_dec_if),
        .aluop_o     (dec_aluop),
        .alusel_o    (dec_alusel),
        .wd_o        (dec_wd),
        .mov_cond_o  (dec_mov_cond),
        .instvalid_o (dec_instvalid)
    );

    id_regfile u_id_regfile (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd         (u_dec_if),
        .wb_we_i    (wb_we_i),
        .wb_addr_i  (wb_addr_i),
        .wb_wdata_i (wb_wdata_i),
        .rdata1_o   (rf_rdata1),
        .rdata2_o   (rf_rdata2)
    );

    id_operand_sel u_id_operand_sel (
        .sel         (u_dec_if),
        .rdata1_i    (rf_rdata1),
        .rdata2_i    (rf_rdata2),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .reg1_o      (sel_reg1),
        .reg2_o      (sel_reg2)
    );

    // ****************************************
    // ID/EX boundary
    // ****************************************
    id_ex_reg u_id_ex_reg (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .aluop_i     (dec_aluop),
        .alusel_i    (dec_alusel),
        .wd_i        (dec_wd),
        .mov_cond_i  (dec_mov_cond),
        .instvalid_i (dec_instvalid),
        .reg1_i      (sel_reg1),
        .reg2_i      (sel_reg2),
        .aluop_o     (aluop_o),
        .alusel_o    (alusel_o),
        .wd_o        (wd_o),
        .instvalid_o (instvalid_o),
        .reg1_o      (reg1_o),
        .reg2_o      (reg2_o),
        .wreg_o      (wreg_o)
    );

endmodule

// ==== dv/id_stage_assert.sv ====
`timescale 1ns/1ps

module id_stage_assert (
    input logic                   clk,
    input logic                   arst_n_i,
    input mips_isa_pkg::aluop_e   aluop_o,
    input mips_isa_pkg::alusel_e  alusel_o,
    input cpu_cfg_pkg::reg_addr_t wd_o,
    input logic                   instvalid_o,
    input cpu_cfg_pkg::word_t     reg1_o,
    input cpu_cfg_pkg::word_t     reg2_o,
    input logic                   wreg_o
);
    import mips_isa_pkg::*;

    wreg_has_group: assert property (@(posedge clk) wreg_o |-> alusel_o != SEL_NOP)
        else $error("wreg_o high with alusel_o NOP");

    invalid_no_write: assert property (@(posedge clk) !instvalid_o |-> !wreg_o)
        else $error("wreg_o high for an invalid instruction");

    // Async reset holds every output at zero
    reset_values: assert property (@(posedge clk) !arst_n_i |->
        (aluop_o == ALU_NOP && alusel_o == SEL_NOP && wd_o == '0 && !instvalid_o &&
         reg1_o == '0 && reg2_o == '0 && !wreg_o))
        else $error("ID/EX outputs not at reset values during reset");

endmodule

bind id_ex_reg id_stage_assert u_id_stage_assert (.*);

// ==== dv/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;
    import cpu_cfg_pkg::*;
    import mips_isa_pkg::*;

    localparam int  N_RAND  = 200;
    localparam int  N_VEC   = 80 + N_RAND;  // Reset and directed vectors, then random
    localparam time TIMEOUT = (N_VEC + 20) * 100;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        logic      instvalid;
    } exp_t;

    typedef struct packed {
        logic      ex_we;
        reg_addr_t ex_a;
        word_t     ex_d;
        logic      mem_we;
        reg_addr_t mem_a;
        word_t     mem_d;
        logic      wb_we;
        reg_addr_t wb_a;
        word_t     wb_d;
    } fwd_t;

    logic      clk;
    logic      arst_n_i;
    inst_t     inst_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;
    logic      wb_we_i;
    reg_addr_t wb_addr_i;
    word_t     wb_wdata_i;
    aluop_e    aluop_o;
    alusel_e   alusel_o;
    word_t     reg1_o;
    word_t     reg2_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    logic      instvalid_o;

    word_t      rf_shadow [NUM_REGS];
    exp_t       exp_q [$];
    fwd_t       fw;
    int         errors;
    integer     seed;
    logic [5:0] r_fns [18] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV,
                               FN_SRAV, FN_SLT, FN_SLTU, FN_ADD, FN_ADDU, FN_SUB,
                               FN_SUBU, FN_MOVN, FN_MOVZ, FN_SYNC, FN_ADD, FN_OR};
    logic [5:0] i_ops [8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
                              OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU};

    id_stage_top u_id_stage_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0t", TIMEOUT);
        $display("Something failed");
        $finish;
    end

    // ****************************************
    // Reference model
    // ****************************************
    function automatic word_t src_val(input reg_addr_t a, input word_t rf [NUM_REGS],
                                      input fwd_t f);
        if (f.ex_we && f.ex_a == a) return f.ex_d;
        if (f.mem_we && f.mem_a == a) return f.mem_d;
        if (a == '0) return '0;
        if (f.wb_we && f.wb_a == a) return f.wb_d;     // Write-through
        return rf[a];
    endfunction

    function automatic exp_t id_ref(input inst_t inst, input word_t rf [NUM_REGS],
                                    input fwd_t f);
        exp_t       e;
        logic       re1;
        logic       re2;
        word_t      imm;
        mov_cond_e  cond;
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        logic [4:0] sa;
        op   = inst[31:26];
        rs   = inst[25:21];
        rt   = inst[20:16];
        sa   = inst[10:6];
        fn   = inst[5:0];
        e    = '0;
        e.wd = inst[15:11];
        re1  = 1'b0;
        re2  = 1'b0;
        imm  = '0;
        cond = MOV_NEVER;
        if (op == OP_SPECIAL && rs == '0 && (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)) begin
            re2         = 1'b1;
            imm         = {27'b0, sa};
            e.alusel    = SEL_SHIFT;
            e.instvalid = 1'b1;
            cond        = MOV_ALWAYS;
            e.aluop     = (fn == FN_SLL) ? ALU_SLL : (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
        end else if (op == OP_SPECIAL && sa == '0) begin
            re1         = 1'b1;
            re2         = 1'b1;
            e.instvalid = 1'b1;
            cond        = MOV_ALWAYS;
            // Shift functs with rs set are invalid
            case (fn)
                FN_SLLV: e.aluop = ALU_SLLV;
                FN_SRLV: e.aluop = ALU_SRLV;
                FN_SRAV: e.aluop = ALU_SRAV;
                FN_MOVZ: e.aluop = ALU_MOVZ;
                FN_MOVN: e.aluop = ALU_MOVN;
                FN_ADD:  e.aluop = ALU_ADD;
                FN_ADDU: e.aluop = ALU_ADDU;
                FN_SUB:  e.aluop = ALU_SUB;
                FN_SUBU: e.aluop = ALU_SUBU;
                FN_AND:  e.aluop = ALU_AND;
                FN_OR:   e.aluop = ALU_OR;
                FN_XOR:  e.aluop = ALU_XOR;
                FN_NOR:  e.aluop = ALU_NOR;
                FN_SLT:  e.aluop = ALU_SLT;
                FN_SLTU: e.aluop = ALU_SLTU;
                default: e.aluop = ALU_NOP;
            endcase
            case (fn)
                FN_AND, FN_OR, FN_XOR, FN_NOR: e.alusel = SEL_LOGIC;
                FN_SLLV, FN_SRLV, FN_SRAV:     e.alusel = SEL_SHIFT;
                FN_SLT, FN_SLTU, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU: e.alusel = SEL_ARITH;
                FN_MOVN: e.alusel = SEL_MOVE;
                FN_MOVZ: e.alusel = SEL_MOVE;
                FN_SYNC: cond = MOV_NEVER;
                default: e.instvalid = 1'b0;
            endcase
            if (fn == FN_MOVN) cond = MOV_NZ;
            if (fn == FN_MOVZ) cond = MOV_Z;
            if (!e.instvalid) begin
                re1  = 1'b0;
                re2  = 1'b0;
                cond = MOV_NEVER;
            end
        end else if (op inside {OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
                                OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU}) begin
            re1         = 1'b1;
            e.wd        = rt;
            e.instvalid = 1'b1;
            cond        = MOV_ALWAYS;
            e.alusel    = (op inside {OP_ORI, OP_ANDI, OP_XORI, OP_LUI}) ? SEL_LOGIC : SEL_ARITH;
            case (op)
                OP_ORI, OP_LUI: e.aluop = ALU_ORI;
                OP_ANDI:        e.aluop = ALU_ANDI;
                OP_XORI:        e.aluop = ALU_XORI;
                OP_SLTI:        e.aluop = ALU_SLTI;
                OP_SLTIU:       e.aluop = ALU_SLTIU;
                OP_ADDI:        e.aluop = ALU_ADDI;
                default:        e.aluop = ALU_ADDIU;
            endcase
            if (op == OP_LUI) imm = {inst[15:0], 16'h0000};
            else if (e.alusel == SEL_LOGIC) imm = {16'h0000, inst[15:0]};
            else imm = {{16{inst[15]}}, inst[15:0]};
        end else if (op == OP_PREF) begin
            e.instvalid = 1'b1;
        end
        e.reg1 = re1 ? src_val(rs, rf, f) : imm;
        e.reg2 = re2 ? src_val(rt, rf, f) : imm;
        case (cond)
            MOV_ALWAYS: e.wreg = 1'b1;
            MOV_NZ:     e.wreg = (e.reg2 != '0);
            MOV_Z:      e.wreg = (e.reg2 == '0);
            default:    e.wreg = 1'b0;
        endcase
        return e;
    endfunction

    // ****************************************
    // Stimulus helpers
    // ****************************************
    function automatic inst_t r_inst(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sa, fn};
    endfunction

    function automatic inst_t i_inst(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic step(input inst_t inst);
        exp_t e;
        @(posedge clk);
        #5;
        inst_i      = inst;
        ex_wreg_i   = fw.ex_we;
        ex_wd_i     = fw.ex_a;
        ex_wdata_i  = fw.ex_d;
        mem_wreg_i  = fw.mem_we;
        mem_wd_i    = fw.mem_a;
        mem_wdata_i = fw.mem_d;
        wb_we_i     = fw.wb_we;
        wb_addr_i   = fw.wb_a;
        wb_wdata_i  = fw.wb_d;
        e = arst_n_i ? id_ref(inst, rf_shadow, fw) : '0;
        exp_q.push_back(e);
        if (fw.wb_we && fw.wb_a != '0) rf_shadow[fw.wb_a] = fw.wb_d;   // Commits at next edge
        fw = '0;
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // ****************************************
    // Compare process
    // ****************************************
    initial begin
        exp_t e;
        forever begin
            @(posedge clk);
            #1;
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_field("aluop_o", 32'(e.aluop), 32'(aluop_o));
                check_field("alusel_o", 32'(e.alusel), 32'(alusel_o));
                check_field("reg1_o", e.reg1, reg1_o);
                check_field("reg2_o", e.reg2, reg2_o);
                check_field("wd_o", 32'(e.wd), 32'(wd_o));
                check_field("wreg_o", 32'(e.wreg), 32'(wreg_o));
                check_field("instvalid_o", 32'(e.instvalid), 32'(instvalid_o));
            end
        end
    end

    initial begin
        reg_addr_t a;
        reg_addr_t b;
        seed     = 32'h8d84;
        errors   = 0;
        fw       = '0;
        arst_n_i = 1'b0;
        inst_i   = '0;
        {ex_wreg_i, ex_wd_i, ex_wdata_i, mem_wreg_i, mem_wd_i, mem_wdata_i} = '0;
        {wb_we_i, wb_addr_i, wb_wdata_i} = '0;
        foreach (rf_shadow[i]) rf_shadow[i] = '0;

        repeat (8) step($random(seed));     // Outputs must stay at reset values
        @(posedge clk);
        #5;
        arst_n_i = 1'b1;

        // Load the register file through write-back, unknown opcode meanwhile
        for (int r = 1; r < NUM_REGS; r++) begin
            fw.wb_we = 1'b1;
            fw.wb_a  = reg_addr_t'(r);
            fw.wb_d  = $random(seed);
            step(32'hfc00_0000);
        end

        // R-type from the register file, r0 included
        foreach (r_fns[i]) begin
            a = (i == 0) ? 5'd0 : reg_addr_t'($random(seed));
            step(r_inst(a, reg_addr_t'($random(seed)), reg_addr_t'($random(seed)), 5'd0,
                        r_fns[i]));
        end

        foreach (i_ops[i]) step(i_inst(i_ops[i], reg_addr_t'(i + 3), 5'd12,
                                       16'h8000 | 16'(i * 16'h111)));

        step(r_inst(5'd0, 5'd4, 5'd5, 5'd7, FN_SLL));
        step(r_inst(5'd0, 5'd6, 5'd8, 5'd31, FN_SRL));
        step(r_inst(5'd0, 5'd9, 5'd2, 5'd1, FN_SRA));

        // Forwarding priority
        fw = '{1'b1, 5'd5, 32'hEEEE_0001, 1'b1, 5'd5, 32'hAAAA_0002, 1'b0, 5'd0, 32'h0};
        step(r_inst(5'd5, 5'd6, 5'd7, 5'd0, FN_OR));
        fw = '{1'b0, 5'd0, 32'h0, 1'b1, 5'd6, 32'hAAAA_0003, 1'b1, 5'd6, 32'h1234_5678};
        step(r_inst(5'd5, 5'd6, 5'd7, 5'd0, FN_ADD));
        fw = '{1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 1'b1, 5'd9, 32'hC0DE_0009};
        step(r_inst(5'd9, 5'd9, 5'd1, 5'd0, FN_XOR));
        fw = '{1'b1, 5'd10, 32'h5555_0004, 1'b0, 5'd0, 32'h0, 1'b1, 5'd10, 32'h0};
        step(r_inst(5'd10, 5'd11, 5'd3, 5'd0, FN_SUB));

        // MOVN and MOVZ against a forwarded rt
        for (int i = 0; i < 4; i++) begin
            fw.ex_we = 1'b1;
            fw.ex_a  = 5'd4;
            fw.ex_d  = (i % 2 == 0) ? 32'h0 : 32'h0000_0100;
            step(r_inst(5'd3, 5'd4, 5'd7, 5'd0, (i < 2) ? FN_MOVN : FN_MOVZ));
        end

        step(r_inst(5'd0, 5'd0, 5'd0, 5'd0, FN_SYNC));
        step(i_inst(OP_PREF, 5'd3, 5'd4, 16'h0010));
        step(i_inst(6'b011100, 5'd1, 5'd2, 16'h0002));
        step(r_inst(5'd3, 5'd4, 5'd5, 5'd0, FN_SLL));  // SLL with rs set

        // Random mix, small address range for frequent forwarding hits
        for (int n = 0; n < N_RAND; n++) begin
            a  = reg_addr_t'($random(seed) & 7);
            b  = reg_addr_t'($random(seed) & 7);
            fw = '{1'($random(seed)), reg_addr_t'($random(seed) & 7), $random(seed),
                   1'($random(seed)), reg_addr_t'($random(seed) & 7), $random(seed),
                   1'($random(seed)), reg_addr_t'($random(seed) & 7), $random(seed)};
            case (($random(seed) & 32'h7fff_ffff) % 4)
                0: step(r_inst(a, b, 5'd3, 5'd0, r_fns[($random(seed) & 32'h7fff) % 18]));
                1: step(i_inst(i_ops[($random(seed) & 32'h7fff) % 8], a, b, 16'($random(seed))));
                2: step(r_inst(5'd0, b, a, 5'($random(seed)), 6'(($random(seed) & 1) * 2)));
                default: step($random(seed));
            endcase
        end

        @(posedge clk);
        #3;
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/cpu_cfg_pkg.sv
rtl/mips_isa_pkg.sv
rtl/id_dec_if.sv
rtl/id_decoder.sv
rtl/id_regfile.sv
rtl/id_operand_sel.sv
rtl/id_ex_reg.sv
rtl/id_stage_top.sv
dv/id_stage_assert.sv
dv/tb_id_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_id_stage -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
fi
exit 1
